// File: files.f
rtl/elevator_pkg.sv
rtl/button_sampler.sv
rtl/floor_request_cell.sv
rtl/request_queue.sv
rtl/dispatch_unit.sv
rtl/floor_logic_top.sv
verification/floor_logic_properties.sv
verification/floor_logic_tb.sv

// File: Bender.yml
package:
  name: floor_logic

sources:
  - files:
      - rtl/elevator_pkg.sv
      - rtl/button_sampler.sv
      - rtl/floor_request_cell.sv
      - rtl/request_queue.sv
      - rtl/dispatch_unit.sv
      - rtl/floor_logic_top.sv
  - target: test
    files:
      - verification/floor_logic_properties.sv
      - verification/floor_logic_tb.sv

// File: verification/floor_logic_tb.sv
`default_nettype none
`timescale 1ns/100ps

module floor_logic_tb;

    import elevator_pkg::*;

    localparam int clock_period = 8;
    localparam int wait_limit = 20;
    // Cycles for reset, lights, dispatch, gating, doors and capacity
    localparam int run_cycles = 20 + 40 + 150 + 60 + 30 + 100;
    localparam int margin_cycles = 200;

    logic           clock;
    logic           reset_n;
    floor_buttons_t buttons;
    logic           door_open_button;
    logic           door_close_button;
    logic           emergency;
    logic           power;
    car_status_t    status;
    dispatch_cmd_t  command;
    door_permit_t   doors;
    floor_buttons_t lights;

    integer seed = 64;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_start = 0;
    floor_t car_floor;
    // Floors in the order the car should be sent to them
    floor_t expected_order [$];

    floor_logic_top DUT (
        .clock             (clock),
        .reset_n           (reset_n),
        .buttons           (buttons),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .emergency         (emergency),
        .power             (power),
        .status            (status),
        .command           (command),
        .doors             (doors),
        .lights            (lights)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #((run_cycles + margin_cycles) * clock_period);
        $display("Watchdog expired at %0t, the tests did not complete", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int total_failures();
        return errors + DUT.u_props.failures;
    endfunction

    function automatic logic [num_floors-1:0] floor_bit(int floor);
        logic [num_floors-1:0] bits;
        bits = '0;
        bits[floor] = 1'b1;
        return bits;
    endfunction

    function automatic int free_floor(logic [num_floors-1:0] used);
        int floor;
        floor = $unsigned($random(seed)) % num_floors;
        while (used[floor]) begin
            floor = $unsigned($random(seed)) % num_floors;
        end
        return floor;
    endfunction

    task automatic check_equal(string name, int actual, int expected);
        assert (actual == expected)
        else begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        @(negedge clock);
    endtask

    task automatic place_car(floor_t floor, logic moving);
        status.current_floor = floor;
        status.moving        = moving;
    endtask

    // Buttons held for one cycle from a falling edge
    task automatic press(logic [num_floors-1:0] panel, logic [num_floors-1:0] call);
        buttons.panel = panel;
        buttons.call  = call;
        next_cycle();
        buttons = '0;
    endtask

    task automatic wait_for_activate();
        int cycles;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
        end while (!command.activate && cycles < wait_limit);
        assert (command.activate)
        else begin
            $display("Activate stayed low for %0d cycles at %0t", wait_limit, $time);
            errors++;
        end
    endtask

    // Car model: wait for each expected target, travel there and stop
    task automatic serve_requests();
        floor_t target;
        while (expected_order.size() > 0) begin
            target = expected_order.pop_front();
            if (target != car_floor) begin
                place_car(car_floor, 1'b0);
                wait_for_activate();
                check_equal("command.target_floor", command.target_floor, target);
                check_equal("command.direction_up", command.direction_up, target > car_floor);
                place_car(car_floor, 1'b1);
                next_cycle();
                check_equal("command.activate", command.activate, 0);
            end
            place_car(target, 1'b0);
            next_cycle();
            check_equal("lights.panel[target]", lights.panel[target], 0);
            check_equal("lights.call[target]", lights.call[target], 0);
            car_floor = target;
        end
    endtask

    task automatic finish_test(string name);
        int found;
        found = total_failures() - test_start;
        tests_run++;
        if (found != 0) begin
            tests_failed++;
        end
        $display("Test %s done with %0d failures", name, found);
        test_start = total_failures();
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [num_floors-1:0] used;
        logic [num_floors-1:0] group;
        logic                  open_expected;
        logic                  close_expected;
        int                    floor;

        buttons           = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power             = 1'b1;
        status            = '0;
        car_floor         = '0;
        reset_n           = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        next_cycle();
        check_equal("command.activate", command.activate, 0);
        check_equal("lights", lights, 0);
        check_equal("doors", doors, 0);
        finish_test("reset");

        // Light rises on the second edge after sampling, then clears on arrival
        press(floor_bit(5), '0);
        next_cycle();
        check_equal("lights.panel[5]", lights.panel[5], 0);
        next_cycle();
        check_equal("lights.panel[5]", lights.panel[5], 1);
        expected_order.push_back(floor_t'(5));
        serve_requests();
        press('0, floor_bit(5));
        next_cycle();
        // Power off at the lighting edge, so arrival cannot clear the light
        power = 1'b0;
        next_cycle();
        check_equal("lights.call[5]", lights.call[5], 0);
        power = 1'b1;
        finish_test("lights");

        place_car(car_floor, 1'b1);
        used = floor_bit(car_floor);
        repeat (6) begin
            floor = free_floor(used);
            used[floor] = 1'b1;
            if (($random(seed) & 1) != 0) begin
                press(floor_bit(floor), '0);
            end else begin
                press('0, floor_bit(floor));
            end
            expected_order.push_back(floor_t'(floor));
            repeat ($unsigned($random(seed)) % 3) next_cycle();
        end
        // Same cycle presses go lowest floor first
        group = '0;
        repeat (3) begin
            floor = free_floor(used);
            used[floor] = 1'b1;
            group[floor] = 1'b1;
        end
        press(group, '0);
        for (int i = 0; i < num_floors; i++) begin
            if (group[i]) begin
                expected_order.push_back(floor_t'(i));
            end
        end
        repeat (4) next_cycle();
        check_equal("lit floors", lights.panel | lights.call, used & ~floor_bit(car_floor));
        serve_requests();
        finish_test("dispatch");

        place_car(car_floor, 1'b0);
        used = floor_bit(car_floor);
        repeat (2) begin
            floor = free_floor(used);
            used[floor] = 1'b1;
            press(floor_bit(floor), '0);
            expected_order.push_back(floor_t'(floor));
        end
        repeat (3) next_cycle();
        floor = free_floor(used);
        for (int phase = 0; phase < 2; phase++) begin
            emergency = (phase == 0);
            power     = (phase == 0);
            press(floor_bit(floor), floor_bit(floor));
            repeat (3) begin
                next_cycle();
                check_equal("command.activate", command.activate, 0);
            end
            check_equal("lit floors", lights.panel | lights.call, used & ~floor_bit(car_floor));
        end
        emergency = 1'b0;
        power     = 1'b1;
        serve_requests();
        finish_test("gating");

        repeat (20) begin
            door_open_button  = 1'($random(seed));
            door_close_button = 1'($random(seed));
            power             = ($unsigned($random(seed)) % 4) != 0;
            place_car(car_floor, 1'($random(seed)));
            open_expected  = door_open_button && !status.moving && power;
            close_expected = door_close_button && !status.moving && power;
            next_cycle();
            check_equal("doors.open_allowed", doors.open_allowed, open_expected);
            check_equal("doors.close_allowed", doors.close_allowed, close_expected);
        end
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        power             = 1'b1;
        finish_test("doors");

        // Every button at once, each floor is served exactly once
        car_floor = '0;
        place_car(car_floor, 1'b1);
        press('1, '1);
        for (int i = 0; i < num_floors; i++) begin
            expected_order.push_back(floor_t'(i));
        end
        repeat (num_floors + 3) next_cycle();
        check_equal("lights", lights, (1 << (2 * num_floors)) - 1);
        serve_requests();
        repeat (4) begin
            next_cycle();
            check_equal("command.activate", command.activate, 0);
        end
        finish_test("capacity");

        $display("%0d tests run, %0d tests failed, %0d failed checks",
                 tests_run, tests_failed, total_failures());
        if (total_failures() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/floor_logic_properties.sv
`default_nettype none
`timescale 1ns/100ps

module floor_logic_properties (
    input wire                                clock,
    input wire                                reset_n,
    input wire                                emergency,
    input wire                                power,
    input wire                                door_open_button,
    input wire                                door_close_button,
    input elevator_pkg::car_status_t          status,
    input elevator_pkg::dispatch_cmd_t        command,
    input elevator_pkg::door_permit_t         doors,
    input elevator_pkg::floor_buttons_t       lights,
    input wire                                pop
);

    import elevator_pkg::*;

    int   failures = 0;
    logic stopped;

    assign stopped = !status.moving && power;

    ////////////////////
    // Queue and dispatch
    ////////////////////

    no_activate_when_gated: assert property (@(posedge clock) disable iff (!reset_n)
        (!power || emergency) |-> !command.activate)
    else begin
        $error("Car activated while power off or emergency on");
        failures++;
    end

    direction_follows_target: assert property (@(posedge clock) disable iff (!reset_n)
        command.activate |-> !status.moving
            && command.direction_up == (command.target_floor > status.current_floor))
    else begin
        $error("Activate given with wrong direction or moving car");
        failures++;
    end

    pop_on_arrival: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> stopped && command.target_floor == status.current_floor)
    else begin
        $error("Queue head retired away from its floor");
        failures++;
    end

    ////////////////////
    // Lights and doors
    ////////////////////

    // Both lights of the floor the car stands at are dark one edge later
    arrival_clears_lights: assert property (@(posedge clock) disable iff (!reset_n)
        stopped |=> !lights.panel[$past(status.current_floor)]
            && !lights.call[$past(status.current_floor)])
    else begin
        $error("Lights still on after arrival");
        failures++;
    end

    door_permits_follow_buttons: assert property (@(posedge clock) disable iff (!reset_n)
        $past(reset_n) |-> doors.open_allowed == $past(door_open_button && stopped)
            && doors.close_allowed == $past(door_close_button && stopped))
    else begin
        $error("Door permit differs from its qualified button");
        failures++;
    end

endmodule

bind floor_logic_top floor_logic_properties u_props (
    .clock             (clock),
    .reset_n           (reset_n),
    .emergency         (emergency),
    .power             (power),
    .door_open_button  (door_open_button),
    .door_close_button (door_close_button),
    .status            (status),
    .command           (command),
    .doors             (doors),
    .lights            (lights),
    .pop               (pop)
);

`default_nettype wire

// File: rtl/floor_logic_top.sv
`default_nettype none
`timescale 1ns/100ps

module floor_logic_top (
    input  wire                          clock,
    input  wire                          reset_n,
    input  elevator_pkg::floor_buttons_t buttons,
    input  wire                          door_open_button,
    input  wire                          door_close_button,
    input  wire                          emergency,
    input  wire                          power,
    input  elevator_pkg::car_status_t    status,
    output elevator_pkg::dispatch_cmd_t  command,
    output elevator_pkg::door_permit_t   doors,
    output elevator_pkg::floor_buttons_t lights
);

    import elevator_pkg::*;

    floor_buttons_t        presses;
    wire  [num_floors-1:0] panel_lit;
    wire  [num_floors-1:0] call_lit;
    wire  [num_floors-1:0] pending;
    logic [num_floors-1:0] grant;
    floor_t                head;
    logic                  empty;
    logic                  pop;

    ////////////////////
    // Button front end
    ////////////////////

    button_sampler u_sampler (
        .clock     (clock),
        .reset_n   (reset_n),
        .buttons   (buttons),
        .power     (power),
        .emergency (emergency),
        .presses   (presses)
    );

    ////////////////////
    // One cell per floor
    ////////////////////

    for (genvar i = 0; i < num_floors; i++) begin : g_floor
        floor_request_cell #(
            .floor_index (floor_t'(i))
        ) u_cell (
            .clock       (clock),
            .reset_n     (reset_n),
            .panel_press (presses.panel[i]),
            .call_press  (presses.call[i]),
            .status      (status),
            .power       (power),
            .grant       (grant[i]),
            .panel_light (panel_lit[i]),
            .call_light  (call_lit[i]),
            .pending     (pending[i])
        );
    end

    assign lights = '{panel: panel_lit, call: call_lit};

    ////////////////////
    // Queue and dispatch
    ////////////////////

    request_queue u_queue (
        .clock   (clock),
        .reset_n (reset_n),
        .pending (pending),
        .grant   (grant),
        .pop     (pop),
        .head    (head),
        .empty   (empty)
    );

    dispatch_unit u_dispatch (
        .clock             (clock),
        .reset_n           (reset_n),
        .status            (status),
        .power             (power),
        .emergency         (emergency),
        .head              (head),
        .empty             (empty),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .pop               (pop),
        .command           (command),
        .doors             (doors)
    );

endmodule

`default_nettype wire

// File: rtl/dispatch_unit.sv
`default_nettype none
`timescale 1ns/100ps

module dispatch_unit (
    input  wire                         clock,
    input  wire                         reset_n,
    input  elevator_pkg::car_status_t   status,
    input  wire                         power,
    input  wire                         emergency,
    input  elevator_pkg::floor_t        head,
    input  wire                         empty,
    input  wire                         door_open_button,
    input  wire                         door_close_button,
    output logic                        pop,
    output elevator_pkg::dispatch_cmd_t command,
    output elevator_pkg::door_permit_t  doors
);

    logic stopped;
    logic at_head;

    assign stopped = !status.moving && power;
    assign at_head = (head == status.current_floor);

    ////////////////////
    // Car command
    ////////////////////

    always_comb begin
        command.target_floor = head;
        command.direction_up = (head > status.current_floor);
        // Only start the car when there is somewhere else to go
        command.activate = power && !emergency && !status.moving && !empty && !at_head;
    end

    // Arrival at the head retires it
    assign pop = stopped && !empty && at_head;

    ////////////////////
    // Door permits
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            doors <= '0;
        end else begin
            doors.open_allowed  <= stopped && door_open_button;
            doors.close_allowed <= stopped && door_close_button;
        end
    end

endmodule

`default_nettype wire

// File: rtl/request_queue.sv
`default_nettype none
`timescale 1ns/100ps

module request_queue (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire  [elevator_pkg::num_floors-1:0] pending,
    output logic [elevator_pkg::num_floors-1:0] grant,
    input  wire                                 pop,
    output elevator_pkg::floor_t                head,
    output logic                                empty
);

    import elevator_pkg::*;

    floor_t                   store [queue_depth];
    logic [queue_ptr_w-1:0]   wr_ptr;
    logic [queue_ptr_w-1:0]   rd_ptr;
    logic [queue_count_w-1:0] count;
    floor_t                   push_floor;
    logic                     push;
    logic                     do_pop;

    ////////////////////
    // Arbiter
    ////////////////////

    // Isolate the lowest set bit
    assign grant = pending & (~pending + 1'b1);
    assign push  = |pending;

    always_comb begin
        push_floor = '0;
        // Walk downwards so the lowest pending floor is left last
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (pending[i]) begin
                push_floor = floor_t'(i);
            end
        end
    end

    ////////////////////
    // FIFO store
    ////////////////////

    assign empty  = (count == '0);
    assign do_pop = pop && !empty;
    assign head   = store[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            store[wr_ptr] <= push_floor;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Depth is a power of two, so the pointers wrap by themselves
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/floor_request_cell.sv
`default_nettype none
`timescale 1ns/100ps

module floor_request_cell #(
    parameter elevator_pkg::floor_t floor_index = '0
) (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire                       panel_press,
    input  wire                       call_press,
    input  elevator_pkg::car_status_t status,
    input  wire                       power,
    input  wire                       grant,
    output logic                      panel_light,
    output logic                      call_light,
    output logic                      pending
);

    logic at_floor;
    logic arrived;
    logic queued;

    // Car standing still at this floor
    assign at_floor = !status.moving && (status.current_floor == floor_index);

    // Serving the floor needs power as well
    assign arrived = at_floor && power;

    ////////////////////
    // Lights and queued flag
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_light <= 1'b0;
            call_light  <= 1'b0;
            queued      <= 1'b0;
        end else if (arrived) begin
            // Arrival clears everything, even a press in the same cycle
            panel_light <= 1'b0;
            call_light  <= 1'b0;
            queued      <= 1'b0;
        end else begin
            if (panel_press && !at_floor) begin
                panel_light <= 1'b1;
            end
            if (call_press && !at_floor) begin
                call_light <= 1'b1;
            end
            if (grant) begin
                queued <= 1'b1;
            end
        end
    end

    // Lit but not yet handed to the queue
    assign pending = (panel_light || call_light) && !queued;

endmodule

`default_nettype wire

// File: rtl/button_sampler.sv
`default_nettype none
`timescale 1ns/100ps

module button_sampler (
    input  wire                         clock,
    input  wire                         reset_n,
    input  elevator_pkg::floor_buttons_t buttons,
    input  wire                         power,
    input  wire                         emergency,
    output elevator_pkg::floor_buttons_t presses
);

    import elevator_pkg::*;

    floor_buttons_t sample_q;
    floor_buttons_t prev_q;
    floor_buttons_t rising;
    logic           accept;

    // Presses only count while the car is powered and not in emergency
    assign accept = power && !emergency;

    // A bit is new when it is high now and was low one sample earlier
    assign rising = sample_q & ~prev_q;

    ////////////////////
    // Sample and edge detect
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sample_q <= '0;
            prev_q   <= '0;
            presses  <= '0;
        end else begin
            sample_q <= buttons;
            prev_q   <= sample_q;
            // One-cycle strobe per press
            presses  <= accept ? rising : '0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/elevator_pkg.sv
`default_nettype none

package elevator_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Floor 1 is index 0, floor 11 is index 10
    localparam int num_floors = 11;

    // Deeper than the floor count, since a lit floor is queued once only
    localparam int queue_depth = 16;
    localparam int queue_ptr_w = $clog2(queue_depth);
    localparam int queue_count_w = $clog2(queue_depth + 1);

    ////////////////////
    // Types
    ////////////////////

    typedef logic [3:0] floor_t;

    // Raw buttons, press strobes and lights all share this layout
    typedef struct packed {
        logic [num_floors-1:0] panel;
        logic [num_floors-1:0] call;
    } floor_buttons_t;

    // Reported by the car FSM
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // Sent to the car FSM
    typedef struct packed {
        floor_t target_floor;
        logic   direction_up;
        logic   activate;
    } dispatch_cmd_t;

    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_permit_t;

endpackage

`default_nettype wire
